// File: cps15_pkg.sv
//========================================
// Shared constants for the CPS-1.5 memory side
// SDRAM offsets, banks, address widths, download header
// layout, slot indices and the SDRAM read word views
//========================================
package cps15_pkg;

    // Address widths
    localparam int SDRAM_AW = 22;   // SDRAM word address
    localparam int ROM_AW   = 21;   // Main ROM, word address
    localparam int RAM_AW   = 17;   // Work RAM and VRAM, word address
    localparam int SND_AW   = 19;   // Sound CPU ROM, byte address
    localparam int PCM_AW   = 20;   // QSound samples, byte address
    localparam int GFX_AW   = 22;   // Graphics ROM, word address

    // SDRAM word offsets of each region
    localparam logic [SDRAM_AW-1:0] SOUND_OFFSET = 22'h00_0000;
    localparam logic [SDRAM_AW-1:0] PCM_OFFSET   = 22'h10_0000;
    localparam logic [SDRAM_AW-1:0] RAM_OFFSET   = 22'h20_0000;
    localparam logic [SDRAM_AW-1:0] VRAM_OFFSET  = 22'h30_0000;
    localparam logic [SDRAM_AW-1:0] GFX_OFFSET   = 22'h00_0000;

    localparam logic [1:0] BANK_SND  = 2'd0;   // Sound, PCM, RAM and VRAM
    localparam logic [1:0] BANK_MAIN = 2'd1;   // Main CPU ROM
    localparam logic [1:0] BANK_GFX  = 2'd2;

    // Download stream header
    localparam int HEADER_LEN   = 3;    // Sound, PCM and GFX start bytes
    localparam int REGION_SHIFT = 16;   // One header unit is 64 KB

    typedef enum logic [1:0] {
        REG_MAIN,
        REG_SND,
        REG_PCM,
        REG_GFX
    } region_e;

    // Slot indices, lower index wins arbitration
    localparam int SLOT_N   = 5;
    localparam int SLOT_RAM = 0;
    localparam int SLOT_ROM = 1;
    localparam int SLOT_GFX = 2;
    localparam int SLOT_SND = 3;
    localparam int SLOT_PCM = 4;

    // One SDRAM read word
    // halves[0] is the word at the requested address, bytes[0] its low byte
    typedef union packed {
        logic [1:0][15:0] halves;
        logic [3:0][7:0]  bytes;
    } sdram_word_u;

endpackage

// File: cps15_dwnld_cfg.sv
//========================================
// Download header registers
// Holds the sound, PCM and GFX start bytes and tells
// which region a file position falls in
//========================================
`timescale 1ns/1ps

module cps15_dwnld_cfg (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               hdr_we,
    input  logic [1:0]         hdr_idx,
    input  logic [7:0]         hdr_data,
    input  logic [24:0]        file_pos,
    output cps15_pkg::region_e region,
    output logic [24:0]        region_start
);

    logic [7:0]  snd_hdr, pcm_hdr, gfx_hdr;
    logic [24:0] snd_start, pcm_start, gfx_start;

    // All ones until the header arrives, so everything maps to main
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            snd_hdr <= 8'hff;
            pcm_hdr <= 8'hff;
            gfx_hdr <= 8'hff;
        end else if (hdr_we) begin
            case (hdr_idx)
                2'd0:    snd_hdr <= hdr_data;
                2'd1:    pcm_hdr <= hdr_data;
                2'd2:    gfx_hdr <= hdr_data;
                default: ;
            endcase
        end
    end

    // Byte positions of each region start
    assign snd_start = 25'(snd_hdr) << cps15_pkg::REGION_SHIFT;
    assign pcm_start = 25'(pcm_hdr) << cps15_pkg::REGION_SHIFT;
    assign gfx_start = 25'(gfx_hdr) << cps15_pkg::REGION_SHIFT;

    always_comb begin
        if (file_pos < snd_start) begin
            region       = cps15_pkg::REG_MAIN;
            region_start = '0;
        end else if (file_pos < pcm_start) begin
            region       = cps15_pkg::REG_SND;
            region_start = snd_start;
        end else if (file_pos < gfx_start) begin
            region       = cps15_pkg::REG_PCM;
            region_start = pcm_start;
        end else begin
            region       = cps15_pkg::REG_GFX;
            region_start = gfx_start;
        end
    end

endmodule

// File: cps15_dwnld_map.sv
//========================================
// Loader byte stream to SDRAM programming writes
// Header bytes go to the config block, data bytes come
// out one cycle later with address, bank and byte mask
//========================================
`timescale 1ns/1ps

module cps15_dwnld_map (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               downloading,
    input  logic [24:0]        ioctl_addr,
    input  logic [7:0]         ioctl_data,
    input  logic               ioctl_wr,
    input  cps15_pkg::region_e region,
    input  logic [24:0]        region_start,
    output logic               hdr_we,
    output logic [1:0]         hdr_idx,
    output logic [7:0]         hdr_data,
    output logic [24:0]        file_pos,
    output logic [21:0]        prog_addr,
    output logic [7:0]         prog_data,
    output logic [1:0]         prog_mask,
    output logic [1:0]         prog_bank,
    output logic               prog_we
);

    logic        in_hdr;
    logic        data_wr;
    logic [22:0] rel_pos;   // Byte position inside the region
    logic [21:0] base;
    logic [1:0]  bank;

    assign in_hdr   = ioctl_addr < 25'(cps15_pkg::HEADER_LEN);
    assign hdr_we   = downloading & ioctl_wr & in_hdr;
    assign hdr_idx  = ioctl_addr[1:0];
    assign hdr_data = ioctl_data;
    assign data_wr  = downloading & ioctl_wr & ~in_hdr;

    assign file_pos = ioctl_addr - 25'(cps15_pkg::HEADER_LEN);
    assign rel_pos  = 23'(file_pos - region_start);

    always_comb begin
        case (region)
            cps15_pkg::REG_SND: begin
                base = cps15_pkg::SOUND_OFFSET;
                bank = cps15_pkg::BANK_SND;
            end
            cps15_pkg::REG_PCM: begin
                base = cps15_pkg::PCM_OFFSET;
                bank = cps15_pkg::BANK_SND;
            end
            cps15_pkg::REG_GFX: begin
                base = cps15_pkg::GFX_OFFSET;
                bank = cps15_pkg::BANK_GFX;
            end
            default: begin          // Main CPU ROM starts at word zero
                base = '0;
                bank = cps15_pkg::BANK_MAIN;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prog_we <= 1'b0;
        end else begin
            prog_we <= data_wr;
        end
    end

    // Regions start on 64 KB, so bit 0 is the byte lane in the word
    always_ff @(posedge clk) begin
        if (data_wr) begin
            prog_addr <= base + rel_pos[22:1];
            prog_bank <= bank;
            prog_mask <= rel_pos[0] ? 2'b01 : 2'b10;   // Active low
            prog_data <= ioctl_data;
        end
    end

endmodule

// File: cps15_slot_arb.sv
//========================================
// SDRAM slot multiplexer for five requesters
// Fixed priority by slot index, one SDRAM access at a time,
// read data cut to each requester's width
//========================================
`timescale 1ns/1ps

module cps15_slot_arb (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        downloading,
    // Main CPU RAM and VRAM
    input  logic        main_ram_cs,
    input  logic        main_vram_cs,
    input  logic        main_rnw,
    input  logic [cps15_pkg::RAM_AW-1:0] main_ram_addr,
    input  logic [15:0] main_dout,
    input  logic [1:0]  dsn,
    output logic [15:0] main_ram_data,
    output logic        main_ram_ok,
    // Main CPU ROM
    input  logic        main_rom_cs,
    input  logic [cps15_pkg::ROM_AW-1:0] main_rom_addr,
    output logic [15:0] main_rom_data,
    output logic        main_rom_ok,
    // Graphics ROM
    input  logic        gfx_cs,
    input  logic [cps15_pkg::GFX_AW-1:0] gfx_addr,
    output logic [31:0] gfx_data,
    output logic        gfx_ok,
    // Sound CPU ROM and QSound samples
    input  logic        snd_cs,
    input  logic [cps15_pkg::SND_AW-1:0] snd_addr,
    output logic [7:0]  snd_data,
    output logic        snd_ok,
    input  logic        pcm_cs,
    input  logic [cps15_pkg::PCM_AW-1:0] pcm_addr,
    output logic [7:0]  pcm_data,
    output logic        pcm_ok,
    // SDRAM controller
    input  logic        sdram_ack,
    input  logic        data_rdy,
    input  logic [31:0] data_read,
    output logic        sdram_req,
    output logic [21:0] sdram_addr,
    output logic [1:0]  sdram_bank,
    output logic        sdram_rnw,
    output logic [1:0]  sdram_wrmask,
    output logic [15:0] data_write
);

    logic [cps15_pkg::SLOT_N-1:0]   cs_vec, gnt_nxt, gnt, ok_q;
    logic [cps15_pkg::SDRAM_AW-1:0] ram_wa, rom_wa, snd_wa, pcm_wa;
    logic [cps15_pkg::SDRAM_AW-1:0] ram_offset, req_addr;
    logic [1:0]                     req_bank;
    logic                           req_lane, lane;
    logic                           wait_data;     // Acked, data pending
    logic                           start;
    logic                           rd_done;
    cps15_pkg::sdram_word_u         rd_word;

    assign cs_vec[cps15_pkg::SLOT_RAM] = main_ram_cs | main_vram_cs;
    assign cs_vec[cps15_pkg::SLOT_ROM] = main_rom_cs;
    assign cs_vec[cps15_pkg::SLOT_GFX] = gfx_cs;
    assign cs_vec[cps15_pkg::SLOT_SND] = snd_cs;
    assign cs_vec[cps15_pkg::SLOT_PCM] = pcm_cs;

    assign gnt_nxt = cs_vec & -cs_vec;     // Lowest set index wins

    // Idle, not downloading, and not in the ok cycle
    assign start   = ~sdram_req & ~wait_data & ~downloading & ~(|ok_q) & (|cs_vec);
    assign rd_done = wait_data & data_rdy;

    // Word addresses widened to SDRAM size, byte slots drop bit 0
    assign ram_wa = {{(cps15_pkg::SDRAM_AW - cps15_pkg::RAM_AW){1'b0}}, main_ram_addr};
    assign rom_wa = {{(cps15_pkg::SDRAM_AW - cps15_pkg::ROM_AW){1'b0}}, main_rom_addr};
    assign snd_wa = {{(cps15_pkg::SDRAM_AW - cps15_pkg::SND_AW + 1){1'b0}},
                     snd_addr[cps15_pkg::SND_AW-1:1]};
    assign pcm_wa = {{(cps15_pkg::SDRAM_AW - cps15_pkg::PCM_AW + 1){1'b0}},
                     pcm_addr[cps15_pkg::PCM_AW-1:1]};

    // RAM select wins over VRAM
    assign ram_offset = (main_vram_cs & ~main_ram_cs) ? cps15_pkg::VRAM_OFFSET
                                                      : cps15_pkg::RAM_OFFSET;

    always_comb begin
        req_addr = ram_offset + ram_wa;
        req_bank = cps15_pkg::BANK_SND;
        req_lane = 1'b0;
        if (gnt_nxt[cps15_pkg::SLOT_ROM]) begin
            req_addr = rom_wa;                      // No offset in bank 1
            req_bank = cps15_pkg::BANK_MAIN;
        end else if (gnt_nxt[cps15_pkg::SLOT_GFX]) begin
            req_addr = cps15_pkg::GFX_OFFSET + gfx_addr;
            req_bank = cps15_pkg::BANK_GFX;
        end else if (gnt_nxt[cps15_pkg::SLOT_SND]) begin
            req_addr = cps15_pkg::SOUND_OFFSET + snd_wa;
            req_lane = snd_addr[0];
        end else if (gnt_nxt[cps15_pkg::SLOT_PCM]) begin
            req_addr = cps15_pkg::PCM_OFFSET + pcm_wa;
            req_lane = pcm_addr[0];
        end
    end

    // Request, wait for ack, wait for data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sdram_req <= 1'b0;
            wait_data <= 1'b0;
            gnt       <= '0;
            ok_q      <= '0;
        end else begin
            ok_q <= '0;
            if (start) begin
                sdram_req <= 1'b1;
                gnt       <= gnt_nxt;
            end else if (sdram_req && sdram_ack) begin
                sdram_req <= 1'b0;
                wait_data <= 1'b1;
            end else if (rd_done) begin
                wait_data <= 1'b0;
                ok_q      <= gnt;   // One-cycle ok to the granted slot
            end
        end
    end

    // Held stable until the ack
    always_ff @(posedge clk) begin
        if (start) begin
            sdram_addr   <= req_addr;
            sdram_bank   <= req_bank;
            lane         <= req_lane;
            sdram_rnw    <= ~gnt_nxt[cps15_pkg::SLOT_RAM] | main_rnw;
            sdram_wrmask <= gnt_nxt[cps15_pkg::SLOT_RAM] ? dsn : 2'b11;
            data_write   <= main_dout;
        end
    end

    assign rd_word = data_read;

    always_ff @(posedge clk) begin
        if (rd_done) begin
            if (gnt[cps15_pkg::SLOT_RAM]) main_ram_data <= rd_word.halves[0];
            if (gnt[cps15_pkg::SLOT_ROM]) main_rom_data <= rd_word.halves[0];
            if (gnt[cps15_pkg::SLOT_GFX]) gfx_data      <= rd_word;
            if (gnt[cps15_pkg::SLOT_SND]) snd_data      <= rd_word.bytes[{1'b0, lane}];
            if (gnt[cps15_pkg::SLOT_PCM]) pcm_data      <= rd_word.bytes[{1'b0, lane}];
        end
    end

    assign main_ram_ok = ok_q[cps15_pkg::SLOT_RAM];
    assign main_rom_ok = ok_q[cps15_pkg::SLOT_ROM];
    assign gfx_ok      = ok_q[cps15_pkg::SLOT_GFX];
    assign snd_ok      = ok_q[cps15_pkg::SLOT_SND];
    assign pcm_ok      = ok_q[cps15_pkg::SLOT_PCM];

endmodule

// File: cps15_mem_top.sv
//========================================
// Memory side of the CPS-1.5 board
// Loader bytes go to SDRAM programming writes and
// the five CPU/video requesters share the SDRAM
//========================================
`timescale 1ns/1ps

module cps15_mem_top (
    input  logic        clk,
    input  logic        rst_n,
    // ROM download
    input  logic        downloading,
    input  logic [24:0] ioctl_addr,
    input  logic [7:0]  ioctl_data,
    input  logic        ioctl_wr,
    output logic [21:0] prog_addr,
    output logic [7:0]  prog_data,
    output logic [1:0]  prog_mask,
    output logic [1:0]  prog_bank,
    output logic        prog_we,
    // Main CPU RAM and VRAM
    input  logic        main_ram_cs,
    input  logic        main_vram_cs,
    input  logic        main_rnw,
    input  logic [cps15_pkg::RAM_AW-1:0] main_ram_addr,
    input  logic [15:0] main_dout,
    input  logic [1:0]  dsn,
    output logic [15:0] main_ram_data,
    output logic        main_ram_ok,
    // Main CPU ROM
    input  logic        main_rom_cs,
    input  logic [cps15_pkg::ROM_AW-1:0] main_rom_addr,
    output logic [15:0] main_rom_data,
    output logic        main_rom_ok,
    // Graphics ROM
    input  logic        gfx_cs,
    input  logic [cps15_pkg::GFX_AW-1:0] gfx_addr,
    output logic [31:0] gfx_data,
    output logic        gfx_ok,
    // Sound CPU ROM and QSound samples
    input  logic        snd_cs,
    input  logic [cps15_pkg::SND_AW-1:0] snd_addr,
    output logic [7:0]  snd_data,
    output logic        snd_ok,
    input  logic        pcm_cs,
    input  logic [cps15_pkg::PCM_AW-1:0] pcm_addr,
    output logic [7:0]  pcm_data,
    output logic        pcm_ok,
    // SDRAM controller
    input  logic        sdram_ack,
    input  logic        data_rdy,
    input  logic [31:0] data_read,
    output logic        sdram_req,
    output logic [21:0] sdram_addr,
    output logic [1:0]  sdram_bank,
    output logic        sdram_rnw,
    output logic [1:0]  sdram_wrmask,
    output logic [15:0] data_write
);

    logic                hdr_we;
    logic [1:0]          hdr_idx;
    logic [7:0]          hdr_data;
    logic [24:0]         file_pos;      // Stream position past the header
    logic [24:0]         region_start;
    cps15_pkg::region_e  region;

    cps15_dwnld_map i_dwnld_map (.*);

    cps15_dwnld_cfg i_dwnld_cfg (.*);

    cps15_slot_arb i_slot_arb (.*);

endmodule

// File: cps15_mem_props.sv
//========================================
// Handshake assertions for the SDRAM slot multiplexer
// Bound into every cps15_slot_arb instance
//========================================
`timescale 1ns/1ps

module cps15_mem_props (
    input logic        clk,
    input logic        rst_n,
    input logic        downloading,
    input logic        sdram_req,
    input logic        sdram_ack,
    input logic [21:0] sdram_addr,
    input logic [4:0]  ok_vec       // One bit per slot, by slot index
);

    logic hold_err = 1'b0;
    logic ok_err   = 1'b0;
    logic dl_err   = 1'b0;
    logic rst_err  = 1'b0;
    logic any_err;

    assign any_err = hold_err | ok_err | dl_err | rst_err;

    // Request and address stay put until the ack
    req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        sdram_req && !sdram_ack |=> sdram_req && $stable(sdram_addr))
        else begin
            $error("sdram_req or sdram_addr changed before sdram_ack");
            hold_err = 1'b1;
        end

    ok_single: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(ok_vec))
        else begin
            $error("More than one slot ok in the same cycle");
            ok_err = 1'b1;
        end

    // A request may only start from a cycle without download
    no_req_dl: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(sdram_req) |-> !$past(downloading))
        else begin
            $error("sdram_req rose while downloading was high");
            dl_err = 1'b1;
        end

    ok_after_rst: assert property (@(posedge clk) $rose(rst_n) |-> ok_vec == 5'd0)
        else begin
            $error("Slot ok high in the cycle after reset");
            rst_err = 1'b1;
        end

endmodule

bind cps15_slot_arb cps15_mem_props i_mem_props (
    .clk(clk), .rst_n(rst_n), .downloading(downloading), .sdram_req(sdram_req),
    .sdram_ack(sdram_ack), .sdram_addr(sdram_addr),
    .ok_vec({pcm_ok, snd_ok, gfx_ok, main_rom_ok, main_ram_ok})
);

// File: tb_cps15_mem.sv
//========================================
// Testbench for the CPS-1.5 memory side
// Download mapping, slot reads, priority, RAM write and
// download blocking against a random-latency SDRAM model
//========================================
`timescale 1ns/1ps

module tb_cps15_mem;

    localparam int WATCHDOG_CYCLES = 15 * 12 + 14 * 4 + 200;  // Transfers and download bytes
    localparam logic [7:0] SND_HDR = 8'h01, PCM_HDR = 8'h02, GFX_HDR = 8'h04;

    logic        clk = 1'b0, rst_n = 1'b0, downloading = 1'b0, ioctl_wr = 1'b0;
    logic [24:0] ioctl_addr = '0;
    logic [7:0]  ioctl_data = '0, prog_data, snd_data, pcm_data;
    logic [21:0] prog_addr, sdram_addr, gfx_addr = '0;
    logic [1:0]  prog_mask, prog_bank, sdram_bank, sdram_wrmask, dsn = 2'b11;
    logic        prog_we, sdram_req, sdram_rnw, main_rnw = 1'b1;
    logic        main_ram_cs = 1'b0, main_vram_cs = 1'b0, main_rom_cs = 1'b0;
    logic        gfx_cs = 1'b0, snd_cs = 1'b0, pcm_cs = 1'b0;
    logic [16:0] main_ram_addr = '0;
    logic [20:0] main_rom_addr = '0;
    logic [18:0] snd_addr = '0;
    logic [19:0] pcm_addr = '0;
    logic [15:0] main_dout = '0, main_ram_data, main_rom_data, data_write;
    logic [31:0] gfx_data, data_read = '0;
    logic        main_ram_ok, main_rom_ok, gfx_ok, snd_ok, pcm_ok;
    logic        sdram_ack = 1'b0, data_rdy = 1'b0;
    logic [4:0]  ok_vec;
    logic [21:0] last_addr;         // Last request seen by the SDRAM model
    logic [1:0]  last_bank, last_mask;
    logic        last_rnw;
    logic [15:0] last_wdata;
    logic [24:0] dl_pos [8] = '{25'h0_0010, 25'h0_0011, 25'h1_0004, 25'h1_0007,
                                25'h2_0020, 25'h2_abcd, 25'h4_0000, 25'h5_fff3};
    logic [21:0] prio_addr [5] = '{22'h0_0040, 22'h0_0080, 22'h0_00c0, 22'h0_0101, 22'h0_0140};

    assign ok_vec = {pcm_ok, snd_ok, gfx_ok, main_rom_ok, main_ram_ok};

    cps15_mem_top i_cps15_mem_top (.*);

    initial forever #20 clk = ~clk;

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_with_failure("Timeout: the tests did not finish in time");
    end

    always @(negedge clk) begin
        if (i_cps15_mem_top.i_slot_arb.i_mem_props.any_err)
            stop_with_failure("A handshake assertion in the slot arbiter failed");
    end

    // Lower half is the word at addr and upper half the next word
    function automatic logic [31:0] model_word(input logic [21:0] addr);
        logic [21:0] next_addr;
        next_addr = addr + 22'd1;
        return {next_addr[15:0] ^ 16'ha5a5, addr[15:0] ^ 16'ha5a5};
    endfunction

    // {prog_addr, prog_bank, prog_mask} for a file position
    function automatic logic [25:0] expected_prog(input logic [24:0] pos);
        logic [24:0] start, rel;
        logic [21:0] base;
        logic [1:0]  bank;
        start = '0;
        base  = '0;
        bank  = cps15_pkg::BANK_MAIN;
        if (pos >= {1'b0, GFX_HDR, 16'd0}) begin
            start = {1'b0, GFX_HDR, 16'd0};
            base  = cps15_pkg::GFX_OFFSET;
            bank  = cps15_pkg::BANK_GFX;
        end else if (pos >= {1'b0, PCM_HDR, 16'd0}) begin
            start = {1'b0, PCM_HDR, 16'd0};
            base  = cps15_pkg::PCM_OFFSET;
            bank  = cps15_pkg::BANK_SND;
        end else if (pos >= {1'b0, SND_HDR, 16'd0}) begin
            start = {1'b0, SND_HDR, 16'd0};
            base  = cps15_pkg::SOUND_OFFSET;
            bank  = cps15_pkg::BANK_SND;
        end
        rel = pos - start;
        return {base + rel[22:1], bank, rel[0] ? 2'b01 : 2'b10};
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "Run stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else stop_with_failure($sformatf("Mismatch in %s: expected %h, actual %h",
                                         name, expected, actual));
    endtask

    task automatic load_byte(input logic [24:0] addr, input logic [7:0] data,
                             input logic expect_we, input string name);
        logic [25:0] exp;
        @(negedge clk);
        ioctl_addr = addr;
        ioctl_data = data;
        ioctl_wr   = 1'b1;
        @(negedge clk);
        ioctl_wr = 1'b0;
        check_value({name, " prog_we"}, 32'(expect_we), 32'(prog_we));
        if (expect_we) begin
            exp = expected_prog(addr - 25'(cps15_pkg::HEADER_LEN));
            check_value({name, " prog_addr"}, 32'(exp[25:4]), 32'(prog_addr));
            check_value({name, " prog_bank/mask"}, 32'(exp[3:0]), 32'({prog_bank, prog_mask}));
            check_value({name, " prog_data"}, 32'(data), 32'(prog_data));
        end
        @(negedge clk);
        check_value({name, " prog_we pulse"}, 32'd0, 32'(prog_we));
    endtask

    task automatic request_slot(input int slot, input logic [21:0] addr, input logic vram);
        case (slot)
            cps15_pkg::SLOT_RAM: begin
                main_ram_cs   = ~vram;
                main_vram_cs  = vram;
                main_ram_addr = addr[16:0];
            end
            cps15_pkg::SLOT_ROM: begin
                main_rom_cs   = 1'b1;
                main_rom_addr = addr[20:0];
            end
            cps15_pkg::SLOT_GFX: begin
                gfx_cs   = 1'b1;
                gfx_addr = addr;
            end
            cps15_pkg::SLOT_SND: begin
                snd_cs   = 1'b1;
                snd_addr = addr[18:0];
            end
            default: begin
                pcm_cs   = 1'b1;
                pcm_addr = addr[19:0];
            end
        endcase
    endtask

    task automatic drop_cs(input int slot);
        case (slot)
            cps15_pkg::SLOT_RAM: begin
                main_ram_cs  = 1'b0;
                main_vram_cs = 1'b0;
            end
            cps15_pkg::SLOT_ROM: main_rom_cs = 1'b0;
            cps15_pkg::SLOT_GFX: gfx_cs = 1'b0;
            cps15_pkg::SLOT_SND: snd_cs = 1'b0;
            default:             pcm_cs = 1'b0;
        endcase
    endtask

    // Waits for the next ok and checks it belongs to slot
    task automatic wait_ok(input int slot, input string name);
        int          cycles;
        logic [4:0]  want;
        want   = 5'd1 << slot;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (ok_vec === 5'd0 && cycles < 40);
        if (ok_vec === 5'd0)
            stop_with_failure($sformatf("No ok from slot %0d in %s after 40 cycles", slot, name));
        check_value({name, " ok order"}, 32'(want), 32'(ok_vec));
    endtask

    task automatic finish_slot(input int slot, input logic [21:0] addr, input logic vram,
                               input string name);
        logic [21:0] exp_addr;
        logic [1:0]  exp_bank;
        logic [31:0] word, exp_data, act_data;
        wait_ok(slot, name);
        exp_bank = cps15_pkg::BANK_SND;
        case (slot)
            cps15_pkg::SLOT_RAM: begin
                exp_addr = (vram ? cps15_pkg::VRAM_OFFSET : cps15_pkg::RAM_OFFSET)
                           + {5'd0, addr[16:0]};
                act_data = {16'd0, main_ram_data};
            end
            cps15_pkg::SLOT_ROM: begin
                exp_addr = {1'b0, addr[20:0]};
                exp_bank = cps15_pkg::BANK_MAIN;
                act_data = {16'd0, main_rom_data};
            end
            cps15_pkg::SLOT_GFX: begin
                exp_addr = cps15_pkg::GFX_OFFSET + addr;
                exp_bank = cps15_pkg::BANK_GFX;
                act_data = gfx_data;
            end
            cps15_pkg::SLOT_SND: begin
                exp_addr = cps15_pkg::SOUND_OFFSET + {4'd0, addr[18:1]};
                act_data = {24'd0, snd_data};
            end
            default: begin
                exp_addr = cps15_pkg::PCM_OFFSET + {3'd0, addr[19:1]};
                act_data = {24'd0, pcm_data};
            end
        endcase
        word = model_word(exp_addr);
        if (slot == cps15_pkg::SLOT_GFX)
            exp_data = word;
        else if (slot >= cps15_pkg::SLOT_SND)
            exp_data = {24'd0, addr[0] ? word[15:8] : word[7:0]};   // Byte lane from bit 0
        else
            exp_data = {16'd0, word[15:0]};
        check_value({name, " sdram_addr"}, 32'(exp_addr), 32'(last_addr));
        check_value({name, " sdram_bank"}, 32'(exp_bank), 32'(last_bank));
        check_value({name, " sdram_rnw"}, 32'd1, 32'(last_rnw));
        check_value({name, " data"}, exp_data, act_data);
        drop_cs(slot);
    endtask

    task automatic read_one(input int slot, input logic [21:0] addr, input logic vram,
                            input string name);
        @(negedge clk);
        request_slot(slot, addr, vram);
        finish_slot(slot, addr, vram, name);
    endtask

    // SDRAM model with ack and data each after 1 to 4 cycles
    initial begin : sdram_model
        int unsigned wait_cycles;
        void'($urandom(32'h518c_04f3));
        forever begin
            @(negedge clk);
            if (sdram_req === 1'b1) begin
                last_addr   = sdram_addr;
                last_bank   = sdram_bank;
                last_rnw    = sdram_rnw;
                last_mask   = sdram_wrmask;
                last_wdata  = data_write;
                wait_cycles = $urandom_range(4, 1);
                repeat (wait_cycles - 1) @(negedge clk);
                sdram_ack = 1'b1;
                @(negedge clk);
                sdram_ack   = 1'b0;
                wait_cycles = $urandom_range(4, 1);
                repeat (wait_cycles - 1) @(negedge clk);
                data_rdy  = 1'b1;
                data_read = model_word(last_addr);
                @(negedge clk);
                data_rdy = 1'b0;
            end
        end
    end

    initial begin
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        check_value("reset outputs", 32'd0, 32'({sdram_req, prog_we, ok_vec}));

        // Header then one even and one odd byte per region
        downloading = 1'b1;
        load_byte(25'd0, SND_HDR, 1'b0, "hdr_snd");
        load_byte(25'd1, PCM_HDR, 1'b0, "hdr_pcm");
        load_byte(25'd2, GFX_HDR, 1'b0, "hdr_gfx");
        foreach (dl_pos[i])
            load_byte(dl_pos[i] + 25'(cps15_pkg::HEADER_LEN), 8'(i * 37 + 5), 1'b1,
                      $sformatf("dl_data_%0d", i));
        downloading = 1'b0;
        load_byte(25'h0_0100, 8'h77, 1'b0, "idle_wr");
        load_byte(25'd0, 8'h99, 1'b0, "idle_hdr");
        downloading = 1'b1;     // Sound start must be unchanged
        load_byte(dl_pos[2] + 25'(cps15_pkg::HEADER_LEN), 8'h3c, 1'b1, "idle_hdr_kept");
        downloading = 1'b0;

        read_one(cps15_pkg::SLOT_RAM, 22'h0_1234, 1'b0, "rd_ram");
        read_one(cps15_pkg::SLOT_RAM, 22'h0_1234, 1'b1, "rd_vram");
        read_one(cps15_pkg::SLOT_ROM, 22'h1_5678, 1'b0, "rd_rom");
        read_one(cps15_pkg::SLOT_GFX, 22'h2a_bcde, 1'b0, "rd_gfx");
        read_one(cps15_pkg::SLOT_SND, 22'h0_4566, 1'b0, "rd_snd_lo");
        read_one(cps15_pkg::SLOT_SND, 22'h0_4567, 1'b0, "rd_snd_hi");
        read_one(cps15_pkg::SLOT_PCM, 22'h0_f8ab0, 1'b0, "rd_pcm_lo");
        read_one(cps15_pkg::SLOT_PCM, 22'h0_f8ab1, 1'b0, "rd_pcm_hi");

        // All five at once are served in index order
        @(negedge clk);
        for (int s = 0; s < cps15_pkg::SLOT_N; s++)
            request_slot(s, prio_addr[s], 1'b0);
        for (int s = 0; s < cps15_pkg::SLOT_N; s++)
            finish_slot(s, prio_addr[s], 1'b0, "priority");

        @(negedge clk);
        request_slot(cps15_pkg::SLOT_RAM, 22'h0_0321, 1'b0);
        main_rnw  = 1'b0;
        main_dout = 16'h5ac3;
        dsn       = 2'b01;
        wait_ok(cps15_pkg::SLOT_RAM, "ram_write");
        check_value("ram_write sdram_addr", 32'(cps15_pkg::RAM_OFFSET + 22'h0_0321),
                    32'(last_addr));
        check_value("ram_write rnw/mask", 32'h0_01, 32'({last_rnw, 3'd0, last_mask}));
        check_value("ram_write data_write", 32'h5ac3, 32'(last_wdata));
        drop_cs(cps15_pkg::SLOT_RAM);
        main_rnw = 1'b1;
        dsn      = 2'b11;

        // No request while the loader is active
        @(negedge clk);
        downloading = 1'b1;
        request_slot(cps15_pkg::SLOT_SND, 22'h0_2345, 1'b0);
        repeat (8) begin
            @(negedge clk);
            check_value("dl_block sdram_req", 32'd0, 32'(sdram_req));
        end
        downloading = 1'b0;
        finish_slot(cps15_pkg::SLOT_SND, 22'h0_2345, 1'b0, "dl_block");

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: all.f
cps15_pkg.sv
cps15_dwnld_cfg.sv
cps15_dwnld_map.sv
cps15_slot_arb.sv
cps15_mem_top.sv
cps15_mem_props.sv
tb_cps15_mem.sv

// File: Makefile
# Verilator lint and simulation for the CPS-1.5 memory side

RTL = cps15_pkg.sv cps15_dwnld_cfg.sv cps15_dwnld_map.sv cps15_slot_arb.sv cps15_mem_top.sv

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module cps15_mem_top $(RTL)

sim:
	verilator --binary --timing --assert -f all.f --top-module tb_cps15_mem -o sim_tb
	./obj_dir/sim_tb +verilator+error+limit+100

clean:
	rm -rf obj_dir
